/* logic/addr_gen.sv */
`timescale 1ns/1ps

module addr_gen (
    input  logic            clk,
    input  logic            rst_n,
    operand_if.cons         opnd,
    output logic            valid_out,
    output rrag_pkg::tag_t  tag_out,
    output logic [31:0]     data_out,
    output logic [31:0]     mem_addr,
    output logic [31:0]     mem_end,
    output logic            end_valid
);
    import rrag_pkg::*;
    import seg_pkg::*;

    logic [31:0] scaled_idx;
    logic [31:0] raw_off;
    logic [31:0] off;
    logic [32:0] end_full;
    logic [31:0] end_off;
    logic [31:0] seg_lin;
    logic [2:0]  nbytes;
    logic        end_ok;

    // operand width in bytes, reserved size treated as dword
    function automatic logic [2:0] size_bytes(op_size_t sz);
        logic [2:0] n;
        case (sz)
            SZ_BYTE:  n = 3'd1;
            SZ_WORD:  n = 3'd2;
            SZ_DWORD: n = 3'd4;
            default:  n = 3'd4;
        endcase
        return n;
    endfunction

    // ##############################
    // effective address
    // ##############################

    assign scaled_idx = opnd.index_val << opnd.scale;
    assign raw_off    = opnd.base_val + scaled_idx + opnd.disp;

    // 16-bit mode wraps inside the segment
    assign off = opnd.addr32 ? raw_off : {16'h0, raw_off[15:0]};

    assign seg_lin = {16'h0, opnd.seg_base} << SEG_SHIFT;

    // ##############################
    // end address and limit
    // ##############################

    assign nbytes   = size_bytes(opnd.size);
    assign end_full = {1'b0, off} + {30'h0, nbytes - 3'd1};
    assign end_off  = opnd.addr32 ? end_full[31:0] : {16'h0, end_full[15:0]};

    // unwrapped end so a carry out of the offset fails the check
    assign end_ok = end_full <= {13'h0, opnd.seg_lim};

    // ##############################
    // result register
    // ##############################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= opnd.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (opnd.valid) begin
            tag_out   <= opnd.tag;
            data_out  <= opnd.data;
            mem_addr  <= seg_lin + off;
            mem_end   <= seg_lin + end_off;
            end_valid <= end_ok;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(valid_out)
    );

endmodule

/* logic/operand_if.sv */
`timescale 1ns/1ps

interface operand_if;
    import rrag_pkg::*;
    import seg_pkg::*;

    // latch holds an item
    logic       valid;
    tag_t       tag;

    // sized data operand
    logic [31:0] data;

    // address inputs
    logic [31:0] base_val;
    logic [31:0] index_val;
    logic [1:0]  scale;
    logic [31:0] disp;
    seg_base_t   seg_base;
    seg_lim_t    seg_lim;
    op_size_t    size;
    logic        addr32;

    modport prod (
        output valid, tag, data,
        output base_val, index_val, scale, disp,
        output seg_base, seg_lim, size, addr32
    );

    modport cons (
        input valid, tag, data,
        input base_val, index_val, scale, disp,
        input seg_base, seg_lim, size, addr32
    );

endinterface

/* logic/reg_read.sv */
`timescale 1ns/1ps

module reg_read (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                valid_in,
    input  rrag_pkg::reg_id_t   data_reg,
    input  rrag_pkg::reg_id_t   base_reg,
    input  rrag_pkg::reg_id_t   index_reg,
    input  logic                use_base,
    input  logic                use_index,
    input  logic [1:0]          scale,
    input  logic [31:0]         disp,
    input  seg_pkg::seg_id_t    seg_sel,
    input  rrag_pkg::op_size_t  opsize,
    input  logic                addr32,
    input  rrag_pkg::reg_id_t   dest_reg,
    input  logic                dest_ld,

    input  logic                wb_valid,
    input  rrag_pkg::reg_id_t   wb_reg,
    input  logic [31:0]         wb_data,
    input  rrag_pkg::op_size_t  wb_size,
    input  rrag_pkg::tag_t      wb_tag,

    input  logic                seg_wb_valid,
    input  seg_pkg::seg_id_t    seg_wb_sel,
    input  seg_pkg::seg_base_t  seg_wb_base,

    output logic                stall,
    operand_if.prod             opnd
);
    import rrag_pkg::*;
    import seg_pkg::*;

    gpr_word_u          gpr [NUM_GPR];
    logic [NUM_GPR-1:0] pend;
    tag_t               pend_tag [NUM_GPR];
    seg_base_t          seg_base [NUM_SEG];
    tag_t               tag_cnt;

    logic accept;
    logic mark;
    logic seg_ok;
    logic seg_wb_ok;

    // zero-extending sized read
    function automatic logic [31:0] read_sized(gpr_word_u w, op_size_t sz);
        logic [31:0] r;
        case (sz)
            SZ_BYTE: r = {24'h0, w.split.lo};
            SZ_WORD: r = {16'h0, w.split.mid, w.split.lo};
            default: r = w.dword;
        endcase
        return r;
    endfunction

    // merge a writeback into the old word
    function automatic gpr_word_u merge_wb(gpr_word_u old, op_size_t sz, logic [31:0] d);
        gpr_word_u w;
        w = old;
        case (sz)
            SZ_BYTE: w.split.lo = d[7:0];
            SZ_WORD: begin
                w.split.mid = d[15:8];
                w.split.lo  = d[7:0];
            end
            default: w.dword = d;
        endcase
        return w;
    endfunction

    // ##############################
    // stall and acceptance
    // ##############################

    assign stall = valid_in && (pend[data_reg] ||
                                (use_base && pend[base_reg]) ||
                                (use_index && pend[index_reg]));

    assign accept    = valid_in && !stall;
    assign mark      = accept && dest_ld;
    assign seg_ok    = seg_sel < NUM_SEG;
    assign seg_wb_ok = seg_wb_sel < NUM_SEG;

    // ##############################
    // register and segment files
    // ##############################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                gpr[i] <= '0;
            end
            for (int s = 0; s < NUM_SEG; s++) begin
                seg_base[s] <= '0;
            end
        end else begin
            if (wb_valid) begin
                gpr[wb_reg] <= merge_wb(gpr[wb_reg], wb_size, wb_data);
            end
            if (seg_wb_valid && seg_wb_ok) begin
                seg_base[seg_wb_sel] <= seg_wb_base;
            end
        end
    end

    // scoreboard, a new mark overrides a clear on the same register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend <= '0;
            for (int i = 0; i < NUM_GPR; i++) begin
                pend_tag[i] <= '0;
            end
            tag_cnt <= '0;
        end else begin
            if (wb_valid && pend[wb_reg] && (pend_tag[wb_reg] == wb_tag)) begin
                pend[wb_reg] <= 1'b0;
            end
            if (mark) begin
                pend[dest_reg]     <= 1'b1;
                pend_tag[dest_reg] <= tag_cnt;
            end
            if (accept) begin
                tag_cnt <= tag_cnt + 1'b1;
            end
        end
    end

    // ##############################
    // operand latch
    // ##############################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            opnd.valid <= 1'b0;
        end else begin
            opnd.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opnd.tag       <= tag_cnt;
            opnd.data      <= read_sized(gpr[data_reg], opsize);
            opnd.base_val  <= use_base ? gpr[base_reg].dword : 32'h0;
            opnd.index_val <= use_index ? gpr[index_reg].dword : 32'h0;
            opnd.scale     <= scale;
            opnd.disp      <= disp;
            opnd.seg_base  <= seg_ok ? seg_base[seg_sel] : '0;
            opnd.seg_lim   <= seg_ok ? SEG_LIMITS[seg_sel] : '0;
            opnd.size      <= opsize;
            opnd.addr32    <= addr32;
        end
    end

    // a stalled cycle adds no pending bit at the next edge
    a_no_mark_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> ((pend & ~$past(pend)) == '0)
    );

    a_stall_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        !valid_in |-> !stall
    );

endmodule

/* logic/rrag_pkg.sv */
package rrag_pkg;

    // general register file
    localparam int NUM_GPR = 8;

    typedef logic [2:0] reg_id_t;

    // operand size codes, 3 is reserved
    typedef logic [1:0] op_size_t;

    localparam op_size_t SZ_BYTE  = 2'd0;
    localparam op_size_t SZ_WORD  = 2'd1;
    localparam op_size_t SZ_DWORD = 2'd2;

    // instruction tag, matched at writeback
    typedef logic [3:0] tag_t;

    // ##############################
    // register word views
    // ##############################

    typedef struct packed {
        logic [15:0] hi;
        logic [7:0]  mid;
        logic [7:0]  lo;
    } gpr_split_t;

    // one 32-bit register word
    // split view for sized access, dword view for addressing
    typedef union packed {
        logic [31:0] dword;
        gpr_split_t  split;
    } gpr_word_u;

endpackage

/* logic/rrag_top.sv */
`timescale 1ns/1ps

module rrag_top (
    input  logic                clk,
    input  logic                rst_n,

    // request
    input  logic                valid_in,
    input  rrag_pkg::reg_id_t   data_reg,
    input  rrag_pkg::reg_id_t   base_reg,
    input  rrag_pkg::reg_id_t   index_reg,
    input  logic                use_base,
    input  logic                use_index,
    input  logic [1:0]          scale,
    input  logic [31:0]         disp,
    input  seg_pkg::seg_id_t    seg_sel,
    input  rrag_pkg::op_size_t  opsize,
    input  logic                addr32,
    input  rrag_pkg::reg_id_t   dest_reg,
    input  logic                dest_ld,

    // register writeback
    input  logic                wb_valid,
    input  rrag_pkg::reg_id_t   wb_reg,
    input  logic [31:0]         wb_data,
    input  rrag_pkg::op_size_t  wb_size,
    input  rrag_pkg::tag_t      wb_tag,

    // segment writeback
    input  logic                seg_wb_valid,
    input  seg_pkg::seg_id_t    seg_wb_sel,
    input  seg_pkg::seg_base_t  seg_wb_base,

    output logic                stall,
    output logic                valid_out,
    output rrag_pkg::tag_t      tag_out,
    output logic [31:0]         data_out,
    output logic [31:0]         mem_addr,
    output logic [31:0]         mem_end,
    output logic                end_valid
);

    operand_if opnd ();

    reg_read i_reg_read (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .data_reg     (data_reg),
        .base_reg     (base_reg),
        .index_reg    (index_reg),
        .use_base     (use_base),
        .use_index    (use_index),
        .scale        (scale),
        .disp         (disp),
        .seg_sel      (seg_sel),
        .opsize       (opsize),
        .addr32       (addr32),
        .dest_reg     (dest_reg),
        .dest_ld      (dest_ld),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .wb_size      (wb_size),
        .wb_tag       (wb_tag),
        .seg_wb_valid (seg_wb_valid),
        .seg_wb_sel   (seg_wb_sel),
        .seg_wb_base  (seg_wb_base),
        .stall        (stall),
        .opnd         (opnd.prod)
    );

    addr_gen i_addr_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .opnd      (opnd.cons),
        .valid_out (valid_out),
        .tag_out   (tag_out),
        .data_out  (data_out),
        .mem_addr  (mem_addr),
        .mem_end   (mem_end),
        .end_valid (end_valid)
    );

endmodule

/* logic/seg_pkg.sv */
package seg_pkg;

    // es, cs, ss, ds, fs, gs
    localparam int NUM_SEG = 6;

    typedef logic [2:0]  seg_id_t;
    typedef logic [15:0] seg_base_t;
    typedef logic [19:0] seg_lim_t;

    // selector base moves up by this many bits to form the linear base
    localparam int SEG_SHIFT = 16;

    // ##############################
    // fixed limits per segment
    // ##############################

    localparam seg_lim_t SEG_LIMITS [NUM_SEG] = '{
        20'h0FFFF,
        20'h0FFFF,
        20'h00FFF,
        20'h000FF,
        20'hFFFFF,
        20'h0FFFF
    };

endpackage

/* sim.f */
logic/rrag_pkg.sv
logic/seg_pkg.sv
logic/operand_if.sv
logic/reg_read.sv
logic/addr_gen.sv
logic/rrag_top.sv
+incdir+tests
tests/rrag_tb.sv

/* tests/rrag_checks.svh */
// ##############################
// reset behavior
// ##############################

c_reset_quiet: assert property (@(posedge clk) (!rst_n && cycles > 0) |-> !stall && !valid_out)
    else report_fail("reset_quiet", 0, $sampled({stall, valid_out}));

c_first_cycle: assert property (@(posedge clk) $rose(rst_n) |-> !stall && !valid_out)
    else report_fail("first_cycle", 0, $sampled({stall, valid_out}));

// ##############################
// strobe levels
// ##############################

c_stall: assert property (@(posedge clk) disable iff (!rst_n) stall == m_stall)
    else report_fail("stall", $sampled(m_stall), $sampled(stall));

c_valid: assert property (@(posedge clk) disable iff (!rst_n) valid_out == e_v)
    else report_fail("valid_out", $sampled(e_v), $sampled(valid_out));

// ##############################
// results
// ##############################

// tag sequence and mirror tag
c_tag: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out |-> tag_out == e_tag)
    else report_fail("tag_out", $sampled(e_tag), $sampled(tag_out));

// sized reads after merging writebacks
c_data: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out |-> data_out == e_data)
    else report_fail("data_out", $sampled(e_data), $sampled(data_out));

c_addr: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out |-> mem_addr == e_addr)
    else report_fail("mem_addr", $sampled(e_addr), $sampled(mem_addr));

c_end: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out |-> mem_end == e_end)
    else report_fail("mem_end", $sampled(e_end), $sampled(mem_end));

c_limit: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out |-> end_valid == e_ev)
    else report_fail("end_valid", $sampled(e_ev), $sampled(end_valid));

// a stale writeback tag keeps the stall
c_stale_wb: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_in && stall && !use_base && !use_index && wb_valid &&
     wb_reg == data_reg && wb_tag != m_ptag[data_reg]) |=> !valid_in || stall)
    else report_fail("stale_wb", 1, $sampled(stall));

// a stalled request completes two edges after its release
c_release: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_in && stall) ##1 (valid_in && !stall) |=> ##1 valid_out)
    else report_fail("release", 1, $sampled(valid_out));

// tags count completed results and wrap
c_tag_step: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out |-> tag_out == tag_t'(done_cnt))
    else report_fail("tag_step", tag_t'($sampled(done_cnt)), $sampled(tag_out));

/* tests/rrag_tb.sv */
`timescale 1ns/1ps

module rrag_tb;
    import rrag_pkg::*;
    import seg_pkg::*;

    localparam int MAX_CYCLES = 3000;
    localparam int PHASE_LEN  = 250;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic valid_in, use_base, use_index, addr32, dest_ld;
    reg_id_t data_reg, base_reg, index_reg, dest_reg, wb_reg;
    logic [1:0] scale;
    logic [31:0] disp, wb_data;
    seg_id_t seg_sel, seg_wb_sel;
    op_size_t opsize, wb_size;
    logic wb_valid, seg_wb_valid;
    tag_t wb_tag;
    seg_base_t seg_wb_base;
    logic stall, valid_out, end_valid;
    tag_t tag_out;
    logic [31:0] data_out, mem_addr, mem_end;

    int seed = 32'h85e0_010a;
    int cycles = 0;
    int errors = 0;

    // completed results seen so far
    int done_cnt = 0;

    // mirror state
    logic [31:0] m_gpr [8];
    logic [7:0]  m_pend;
    tag_t        m_ptag [8];
    logic [15:0] m_seg [6];
    tag_t        m_tag;
    logic [19:0] lim_tab [6] = '{
        20'h0FFFF, 20'h0FFFF, 20'h00FFF,
        20'h000FF, 20'hFFFFF, 20'h0FFFF
    };
    logic        m_stall, m_acc;

    // expected results per pipeline stage
    logic s1_v, e_v;
    tag_t s1_tag, e_tag;
    logic [31:0] s1_data, s1_addr, s1_end, e_data, e_addr, e_end;
    logic s1_ev, e_ev;

    rrag_top i_rrag_top (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles", cycles);
            $display("Checks failed");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        if (rst_n && valid_out)
            done_cnt <= done_cnt + 1;
    end

    function automatic logic [31:0] sized(logic [31:0] w, op_size_t sz);
        if (sz == 2'd0)
            return {24'h0, w[7:0]};
        else if (sz == 2'd1)
            return {16'h0, w[15:0]};
        return w;
    endfunction

    function automatic logic [31:0] merged(logic [31:0] w, op_size_t sz, logic [31:0] d);
        if (sz == 2'd0)
            return {w[31:8], d[7:0]};
        else if (sz == 2'd1)
            return {w[31:16], d[15:0]};
        return d;
    endfunction

    assign m_stall = valid_in && (m_pend[data_reg] || (use_base && m_pend[base_reg]) ||
                                  (use_index && m_pend[index_reg]));
    assign m_acc = valid_in && !m_stall;

    always @(posedge clk) begin
        logic [31:0] off, eoff, lin, nb;
        logic [32:0] efull;
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                m_gpr[i] <= '0;
                m_ptag[i] <= '0;
            end
            for (int s = 0; s < 6; s++) begin
                m_seg[s] <= '0;
            end
            m_pend <= '0;
            m_tag <= '0;
            s1_v <= 1'b0;
            e_v <= 1'b0;
        end else begin
            if (wb_valid) begin
                m_gpr[wb_reg] <= merged(m_gpr[wb_reg], wb_size, wb_data);
                if (m_pend[wb_reg] && m_ptag[wb_reg] == wb_tag)
                    m_pend[wb_reg] <= 1'b0;
            end
            if (seg_wb_valid)
                m_seg[seg_wb_sel] <= seg_wb_base;
            if (m_acc && dest_ld) begin
                m_pend[dest_reg] <= 1'b1;
                m_ptag[dest_reg] <= m_tag;
            end
            off = (use_base ? m_gpr[base_reg] : 32'h0) + disp +
                  ((use_index ? m_gpr[index_reg] : 32'h0) << scale);
            if (!addr32)
                off = {16'h0, off[15:0]};
            nb = (opsize == 2'd0) ? 1 : (opsize == 2'd1) ? 2 : 4;
            efull = {1'b0, off} + nb - 1;
            eoff = addr32 ? efull[31:0] : {16'h0, efull[15:0]};
            lin = {m_seg[seg_sel], 16'h0};
            s1_v <= m_acc;
            if (m_acc) begin
                m_tag <= m_tag + 1'b1;
                s1_tag <= m_tag;
                s1_data <= sized(m_gpr[data_reg], opsize);
                s1_addr <= lin + off;
                s1_end <= lin + eoff;
                s1_ev <= efull <= {13'h0, lim_tab[seg_sel]};
            end
            e_v <= s1_v;
            if (s1_v) begin
                e_tag <= s1_tag;
                e_data <= s1_data;
                e_addr <= s1_addr;
                e_end <= s1_end;
                e_ev <= s1_ev;
            end
        end
    end

    task automatic report_fail(string name, logic [31:0] exp, logic [31:0] act);
        errors++;
        $display("Fail %s expected %h actual %h", name, exp, act);
        $display("Checks failed");
        $fatal(1);
    endtask

    `include "rrag_checks.svh"

    // one cycle of stimulus holding a stalled request
    task automatic drive_cycle(int phase);
        int s;
        logic [7:0] r;
        reg_id_t w;
        @(posedge clk);
        r = $random(seed);
        w = $random(seed);
        wb_valid <= r[0] | r[1];
        wb_reg <= w;
        wb_size <= $unsigned($random(seed)) % 3;
        wb_data <= $random(seed);
        wb_tag <= r[3:2] != 0 ? m_ptag[w] : tag_t'($random(seed));
        seg_wb_valid <= (r[7:4] == 0);
        seg_wb_sel <= $unsigned($random(seed)) % 6;
        seg_wb_base <= $random(seed);
        if (valid_in && m_stall)
            return;
        valid_in <= r[4] | r[5] | (phase < 2);
        data_reg <= $random(seed);
        base_reg <= $random(seed);
        index_reg <= $random(seed);
        dest_reg <= $random(seed);
        dest_ld <= (phase > 1) && r[6];
        scale <= $random(seed);
        opsize <= $unsigned($random(seed)) % 3;
        s = $unsigned($random(seed)) % 6;
        seg_sel <= s;
        if (phase >= 6 && r[7]) begin
            // offsets around the segment limit
            use_base <= 1'b0;
            use_index <= 1'b0;
            addr32 <= 1'b1;
            disp <= {12'h0, lim_tab[s]} + ($unsigned($random(seed)) % 6) - 4;
        end else begin
            use_base <= $random(seed);
            use_index <= $random(seed);
            addr32 <= $random(seed);
            disp <= $random(seed);
        end
    endtask

    initial begin
        {valid_in, use_base, use_index, addr32, dest_ld, wb_valid, seg_wb_valid} = '0;
        {data_reg, base_reg, index_reg, dest_reg, wb_reg, seg_sel, seg_wb_sel} = '0;
        {scale, opsize, wb_size, wb_tag} = '0;
        {disp, wb_data, seg_wb_base} = '0;
        // a request already waits through reset
        valid_in = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int p = 0; p < 10; p++) begin
            repeat (PHASE_LEN) drive_cycle(p);
        end
        @(posedge clk);
        valid_in <= 1'b0;
        wb_valid <= 1'b0;
        repeat (4) @(posedge clk);
        if (errors == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule
